/* rename_cfg_pkg.sv */
// sizing for the rename map: 32 architectural registers, 64 physical tags
// physical tags must cover the identity mapping, so PHYS_REGS >= ARCH_REGS
// one dispatch slot, two writeback ports
package rename_cfg_pkg;

    // ====================================================================
    // table geometry
    // ====================================================================
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int WB_PORTS  = 2;

    // index and tag widths
    localparam int ARCH_IDX_W = $clog2(ARCH_REGS);
    localparam int PHYS_TAG_W = $clog2(PHYS_REGS);

    // architectural register index
    typedef logic [ARCH_IDX_W-1:0] arch_idx_t;

    // physical register tag
    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;

    // hardwired zero register, its mapping never changes
    localparam arch_idx_t ZERO_REG = '0;

endpackage

/* rename_types_pkg.sv */
// bundles that move between the rename map blocks
// map_table_t is the whole table, also used as snapshot in and out
// entry 0 of a packed table is architectural register 0
package rename_types_pkg;
    import rename_cfg_pkg::*;

    // ====================================================================
    // table storage
    // ====================================================================
    // one mapping: physical tag and its value-ready bit
    typedef struct packed {
        phys_tag_t tag;
        logic      ready;
    } map_entry_t;

    // full map, indexed by architectural register
    typedef map_entry_t [ARCH_REGS-1:0] map_table_t;

    // ====================================================================
    // request and response bundles
    // ====================================================================
    // source operand lookup
    typedef struct packed {
        arch_idx_t rs1;
        arch_idx_t rs2;
    } src_req_t;

    typedef struct packed {
        phys_tag_t rs1_tag;
        logic      rs1_ready;
        phys_tag_t rs2_tag;
        logic      rs2_ready;
    } src_rsp_t;

    // destination rename from dispatch
    typedef struct packed {
        logic      valid;
        logic      is_branch;
        arch_idx_t arch_dst;
        phys_tag_t new_tag;
    } disp_req_t;

    // one writeback port, and all of them together
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } wb_port_t;

    typedef wb_port_t [WB_PORTS-1:0] wb_bus_t;

endpackage

/* wb_tag_match.sv */
// flags every table entry whose tag is being written back this cycle
// purely combinational, one comparator per entry and writeback port
`timescale 1ns/1ps

module wb_tag_match (
    input  rename_types_pkg::map_table_t         table_i,
    input  rename_types_pkg::wb_bus_t            wb_bus_i,
    output logic [rename_cfg_pkg::ARCH_REGS-1:0] wb_hit_o
);
    import rename_cfg_pkg::*;

    // ====================================================================
    // tag compare
    // ====================================================================
    // the hit vector is shared by lookup forwarding and ready marking
    // so the compare array exists only once
    always_comb begin
        wb_hit_o = '0;
        for (int e = 0; e < ARCH_REGS; e++) begin
            // any valid port carrying this entry's tag
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb_bus_i[p].valid && (wb_bus_i[p].tag == table_i[e].tag)) begin
                    wb_hit_o[e] = 1'b1;
                end
            end
        end
    end

    // note: several entries can share one tag after a restore,
    // all of them get flagged

endmodule

/* map_table_regs.sv */
// architectural-to-physical map storage
// synchronous reset loads the identity map, all entries ready
`timescale 1ns/1ps

module map_table_regs (
    input  logic                         clock,
    input  logic                         reset,
    input  rename_types_pkg::map_table_t table_d_i,
    output rename_types_pkg::map_table_t table_q_o
);
    import rename_cfg_pkg::*;

    // ====================================================================
    // state
    // ====================================================================
    // every edge takes the next table, no enable needed since
    // map_next_state returns the old contents when nothing happens
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                // register i lives in physical tag i
                table_q_o[i].tag   <= PHYS_TAG_W'(i);
                table_q_o[i].ready <= 1'b1;
            end
        end else begin
            table_q_o <= table_d_i;
        end
    end

    // note: physical tags ARCH_REGS and up start on the free list,
    // which lives outside this block

endmodule

/* src_lookup.sv */
// source operand and old-tag read ports, zero latency
// ready bits include same-cycle writeback forwarding
// old tag follows the snapshot while a restore is in flight
`timescale 1ns/1ps

module src_lookup (
    input  rename_types_pkg::map_table_t         table_i,
    input  logic [rename_cfg_pkg::ARCH_REGS-1:0] wb_hit_i,
    input  rename_types_pkg::src_req_t           src_req_i,
    input  rename_types_pkg::disp_req_t          disp_req_i,
    input  logic                                 restore_valid_i,
    input  rename_types_pkg::map_table_t         snapshot_i,
    output rename_types_pkg::src_rsp_t           src_rsp_o,
    output rename_cfg_pkg::phys_tag_t            disp_old_phys_o
);

    // ====================================================================
    // source reads
    // ====================================================================
    // rs1
    assign src_rsp_o.rs1_tag   = table_i[src_req_i.rs1].tag;
    // stored ready or the value lands this cycle
    assign src_rsp_o.rs1_ready = table_i[src_req_i.rs1].ready | wb_hit_i[src_req_i.rs1];

    // rs2
    assign src_rsp_o.rs2_tag   = table_i[src_req_i.rs2].tag;
    assign src_rsp_o.rs2_ready = table_i[src_req_i.rs2].ready | wb_hit_i[src_req_i.rs2];

    // ====================================================================
    // old destination tag
    // ====================================================================
    // freed at commit of the renaming instruction, so it must match
    // the mapping the table will actually hold
    always_comb begin
        if (restore_valid_i) begin
            disp_old_phys_o = snapshot_i[disp_req_i.arch_dst].tag;
        end else begin
            disp_old_phys_o = table_i[disp_req_i.arch_dst].tag;
        end
    end

endmodule

/* map_next_state.sv */
// next-state logic of the rename map
// restore beats dispatch; snapshot_o never sees the restore
// checkpoint strobe is combinational and gated only by branch_stall_i
`timescale 1ns/1ps

module map_next_state (
    input  rename_types_pkg::map_table_t         table_i,
    input  logic [rename_cfg_pkg::ARCH_REGS-1:0] wb_hit_i,
    input  rename_types_pkg::disp_req_t          disp_req_i,
    input  rename_types_pkg::wb_bus_t            wb_bus_i,
    input  logic                                 restore_valid_i,
    input  rename_types_pkg::map_table_t         snapshot_i,
    input  logic                                 branch_stall_i,
    output rename_types_pkg::map_table_t         table_d_o,
    output rename_types_pkg::map_table_t         snapshot_o,
    output logic                                 checkpoint_valid_o
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // table after rename and writeback, before any restore
    map_table_t           spec_tbl;
    // table loaded from the snapshot port
    map_table_t           restore_tbl;
    // dispatch that really renames (zero register excluded)
    logic                 do_rename;
    // snapshot tag is being written back this cycle
    logic [ARCH_REGS-1:0] snap_wb_hit;
    // snapshot tag equals the live tag and the live value is ready
    logic [ARCH_REGS-1:0] keep_ready;

    assign do_rename = disp_req_i.valid && (disp_req_i.arch_dst != ZERO_REG);

    // ====================================================================
    // speculative path: writeback marking, then rename
    // ====================================================================
    always_comb begin
        spec_tbl = table_i;
        // untouched entries keep their tag, so the live hit vector applies
        for (int e = 0; e < ARCH_REGS; e++) begin
            if (wb_hit_i[e]) begin
                spec_tbl[e].ready = 1'b1;
            end
        end
        // rename overrides last, the renamed entry never picks up a writeback
        if (do_rename) begin
            spec_tbl[disp_req_i.arch_dst].tag   = disp_req_i.new_tag;
            spec_tbl[disp_req_i.arch_dst].ready = 1'b0;
        end
    end

    // ====================================================================
    // restore path
    // ====================================================================
    always_comb begin
        snap_wb_hit = '0;
        keep_ready  = '0;
        for (int e = 0; e < ARCH_REGS; e++) begin
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb_bus_i[p].valid && (wb_bus_i[p].tag == snapshot_i[e].tag)) begin
                    snap_wb_hit[e] = 1'b1;
                end
            end
            // value may have completed after the snapshot was taken
            keep_ready[e] = (snapshot_i[e].tag == table_i[e].tag) && table_i[e].ready;
            restore_tbl[e].tag   = snapshot_i[e].tag;
            restore_tbl[e].ready = snapshot_i[e].ready | keep_ready[e] | snap_wb_hit[e];
        end
    end

    // restore wins, dispatch in the same cycle is dropped
    assign table_d_o  = restore_valid_i ? restore_tbl : spec_tbl;
    assign snapshot_o = spec_tbl;

    // branch checkpoint, held back while the branch unit stalls
    assign checkpoint_valid_o = disp_req_i.valid & disp_req_i.is_branch & ~branch_stall_i;

endmodule

/* rename_map_top.sv */
// register alias table: 32 arch regs, 64 tags, 1 dispatch, 2 writebacks
// all inputs are valid-qualified single-cycle pulses, no handshake
// lookups are combinational, renames visible one cycle after dispatch
`timescale 1ns/1ps

module rename_map_top (
    input  logic                         clock,
    input  logic                         reset,
    input  rename_types_pkg::src_req_t   src_req_i,
    input  rename_types_pkg::disp_req_t  disp_req_i,
    input  rename_types_pkg::wb_bus_t    wb_bus_i,
    input  logic                         branch_stall_i,
    input  logic                         restore_valid_i,
    input  rename_types_pkg::map_table_t snapshot_i,
    output rename_types_pkg::src_rsp_t   src_rsp_o,
    output rename_cfg_pkg::phys_tag_t    disp_old_phys_o,
    output rename_types_pkg::map_table_t snapshot_o,
    output logic                         checkpoint_valid_o
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // current and next table
    map_table_t           table_q;
    map_table_t           table_d;
    // entries whose tag is on a writeback port
    logic [ARCH_REGS-1:0] wb_hit;

    // ====================================================================
    // storage and tag compare
    // ====================================================================
    map_table_regs u_regs (
        .clock     (clock),
        .reset     (reset),
        .table_d_i (table_d),
        .table_q_o (table_q)
    );

    wb_tag_match u_wb_match (
        .table_i  (table_q),
        .wb_bus_i (wb_bus_i),
        .wb_hit_o (wb_hit)
    );

    // ====================================================================
    // read ports and update
    // ====================================================================
    src_lookup u_lookup (
        .table_i         (table_q),
        .wb_hit_i        (wb_hit),
        .src_req_i       (src_req_i),
        .disp_req_i      (disp_req_i),
        .restore_valid_i (restore_valid_i),
        .snapshot_i      (snapshot_i),
        .src_rsp_o       (src_rsp_o),
        .disp_old_phys_o (disp_old_phys_o)
    );

    map_next_state u_next (
        .table_i            (table_q),
        .wb_hit_i           (wb_hit),
        .disp_req_i         (disp_req_i),
        .wb_bus_i           (wb_bus_i),
        .restore_valid_i    (restore_valid_i),
        .snapshot_i         (snapshot_i),
        .branch_stall_i     (branch_stall_i),
        .table_d_o          (table_d),
        .snapshot_o         (snapshot_o),
        .checkpoint_valid_o (checkpoint_valid_o)
    );

endmodule

/* rename_map_asserts.sv */
// bound checker for rename_map_top, checks are off while reset is high
// shadow map follows the rename, writeback and restore rules
// fail_count is read by the testbench through the u_asserts instance
`timescale 1ns/1ps

module rename_map_asserts (
    input logic                         clock,
    input logic                         reset,
    input rename_types_pkg::src_req_t   src_req_i,
    input rename_types_pkg::disp_req_t  disp_req_i,
    input rename_types_pkg::wb_bus_t    wb_bus_i,
    input logic                         branch_stall_i,
    input logic                         restore_valid_i,
    input rename_types_pkg::map_table_t snapshot_i,
    input rename_types_pkg::src_rsp_t   src_rsp_o,
    input rename_cfg_pkg::phys_tag_t    disp_old_phys_o,
    input rename_types_pkg::map_table_t snapshot_o,
    input logic                         checkpoint_valid_o
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    phys_tag_t  sh_tag [ARCH_REGS];
    logic       sh_rdy [ARCH_REGS];
    map_table_t exp_snap;
    src_rsp_t   exp_rsp;
    phys_tag_t  exp_old;
    int         fail_count = 0;

    // tag t is on some valid writeback port
    function automatic logic on_wb(phys_tag_t t, wb_bus_t bus);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WB_PORTS; p++) begin
            hit |= bus[p].valid && (bus[p].tag == t);
        end
        return hit;
    endfunction

    // ====================================================================
    // shadow map
    // ====================================================================
    always_comb begin
        for (int r = 0; r < ARCH_REGS; r++) begin
            exp_snap[r].tag   = sh_tag[r];
            exp_snap[r].ready = sh_rdy[r] | on_wb(sh_tag[r], wb_bus_i);
        end
        if (disp_req_i.valid && (disp_req_i.arch_dst != ZERO_REG)) begin
            exp_snap[disp_req_i.arch_dst].tag   = disp_req_i.new_tag;
            exp_snap[disp_req_i.arch_dst].ready = 1'b0;
        end
        exp_rsp.rs1_tag   = sh_tag[src_req_i.rs1];
        exp_rsp.rs1_ready = sh_rdy[src_req_i.rs1] | on_wb(sh_tag[src_req_i.rs1], wb_bus_i);
        exp_rsp.rs2_tag   = sh_tag[src_req_i.rs2];
        exp_rsp.rs2_ready = sh_rdy[src_req_i.rs2] | on_wb(sh_tag[src_req_i.rs2], wb_bus_i);
        exp_old = restore_valid_i ? snapshot_i[disp_req_i.arch_dst].tag
                                  : sh_tag[disp_req_i.arch_dst];
    end

    always_ff @(posedge clock) begin
        for (int r = 0; r < ARCH_REGS; r++) begin
            if (reset) begin
                sh_tag[r] <= PHYS_TAG_W'(r);
                sh_rdy[r] <= 1'b1;
            end else if (restore_valid_i) begin
                sh_tag[r] <= snapshot_i[r].tag;
                sh_rdy[r] <= snapshot_i[r].ready | on_wb(snapshot_i[r].tag, wb_bus_i)
                             | ((snapshot_i[r].tag == sh_tag[r]) && sh_rdy[r]);
            end else begin
                sh_tag[r] <= exp_snap[r].tag;
                sh_rdy[r] <= exp_snap[r].ready;
            end
        end
    end

    // ====================================================================
    // output checks
    // ====================================================================
    a_lookup: assert property (@(posedge clock) disable iff (reset) src_rsp_o == exp_rsp)
        else begin $error("source lookup differs from shadow map"); fail_count++; end
    a_old_tag: assert property (@(posedge clock) disable iff (reset)
        disp_req_i.valid |-> disp_old_phys_o == exp_old)
        else begin $error("old tag differs from shadow map"); fail_count++; end
    a_snapshot: assert property (@(posedge clock) disable iff (reset) snapshot_o == exp_snap)
        else begin $error("snapshot output differs from shadow map"); fail_count++; end
    a_checkpoint: assert property (@(posedge clock) disable iff (reset)
        checkpoint_valid_o == (disp_req_i.valid && disp_req_i.is_branch && !branch_stall_i))
        else begin $error("checkpoint strobe wrong"); fail_count++; end

endmodule

bind rename_map_top rename_map_asserts u_asserts (.*);

/* rename_map_tb.sv */
// testbench for rename_map_top, inputs change on the falling edge
// cycle-by-cycle checking sits in the bound rename_map_asserts
// fresh tags come from 32..63, so they never alias an identity mapping
`timescale 1ns/1ps

module rename_map_tb;
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int N_TESTS = 5;

    logic clock;
    logic reset;
    src_req_t src_req;
    disp_req_t disp_req;
    wb_bus_t wb_bus;
    logic branch_stall;
    logic restore_valid;
    map_table_t snap_in;
    src_rsp_t src_rsp;
    phys_tag_t old_phys;
    map_table_t snap_out;
    logic ckpt_valid;
    // expected mapping, kept by the stimulus
    phys_tag_t m_tag [ARCH_REGS];
    logic m_rdy [ARCH_REGS];
    int tag_cnt;
    int test_errs;
    int tests_failed;
    string test_name;

    rename_map_top dut (
        .clock(clock), .reset(reset), .src_req_i(src_req), .disp_req_i(disp_req),
        .wb_bus_i(wb_bus), .branch_stall_i(branch_stall), .restore_valid_i(restore_valid),
        .snapshot_i(snap_in), .src_rsp_o(src_rsp), .disp_old_phys_o(old_phys),
        .snapshot_o(snap_out), .checkpoint_valid_o(ckpt_valid)
    );

    always #5 clock = ~clock;

    // ====================================================================
    // helpers
    // ====================================================================
    task automatic check_val(string what, int exp, int act);
        if (exp != act) begin
            $display("Error %s: %s expected %0d actual %0d", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    // next falling edge, all strobes dropped
    task automatic next_cycle();
        @(negedge clock);
        disp_req = '0;
        wb_bus = '0;
        restore_valid = 1'b0;
        branch_stall = 1'b0;
    endtask

    // rs1 is compared here, rs2 just feeds the bound checker
    task automatic check_lookup(int r);
        src_req.rs1 = arch_idx_t'(r);
        src_req.rs2 = arch_idx_t'(ARCH_REGS - 1 - r);
        #1;
        check_val($sformatf("r%0d tag", r), int'(m_tag[r]), int'(src_rsp.rs1_tag));
        check_val($sformatf("r%0d ready", r), int'(m_rdy[r]), int'(src_rsp.rs1_ready));
    endtask

    // dispatch to r with a fresh tag, old tag compared with the expected map
    task automatic rename(int r, logic branch);
        phys_tag_t t;
        t = phys_tag_t'(ARCH_REGS + (tag_cnt % ARCH_REGS));
        tag_cnt++;
        disp_req = '{valid: 1'b1, is_branch: branch, arch_dst: arch_idx_t'(r), new_tag: t};
        #1;
        check_val("old tag", int'(m_tag[r]), int'(old_phys));
        if (r != 0) begin
            m_tag[r] = t;
            m_rdy[r] = 1'b0;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errs);
            tests_failed++;
        end
    endtask

    // ====================================================================
    // test sequence
    // ====================================================================
    initial begin
        int r;
        int r2;
        int asrt;
        phys_tag_t pend;
        void'($urandom(68571));
        clock = 1'b0;
        reset = 1'b1;
        src_req = '0;
        disp_req = '0;
        wb_bus = '0;
        branch_stall = 1'b0;
        restore_valid = 1'b0;
        snap_in = '0;
        tests_failed = 0;
        tag_cnt = int'($urandom % ARCH_REGS);
        for (int e = 0; e < ARCH_REGS; e++) begin
            m_tag[e] = phys_tag_t'(e);
            m_rdy[e] = 1'b1;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        start_test("reset identity");
        for (int e = 0; e < ARCH_REGS; e++) begin
            next_cycle();
            check_lookup(e);
        end
        end_test();

        start_test("rename");
        for (int k = 0; k < 8; k++) begin
            r = 1 + int'($urandom % (ARCH_REGS - 1));
            next_cycle();
            rename(r, 1'b0);
            next_cycle();
            check_lookup(r);
        end
        // register zero keeps its identity mapping
        next_cycle();
        rename(0, 1'b0);
        next_cycle();
        check_lookup(0);
        end_test();

        start_test("writeback");
        r = 1 + int'($urandom % (ARCH_REGS - 1));
        next_cycle();
        rename(r, 1'b0);
        next_cycle();
        wb_bus[0] = '{valid: 1'b1, tag: m_tag[r]};
        m_rdy[r] = 1'b1;
        check_lookup(r);
        next_cycle();
        check_lookup(r);
        // old tag written back while r is renamed again
        next_cycle();
        rename(r, 1'b0);
        next_cycle();
        pend = m_tag[r];
        rename(r, 1'b0);
        wb_bus[1] = '{valid: 1'b1, tag: pend};
        next_cycle();
        check_lookup(r);
        end_test();

        start_test("restore");
        r = 1 + int'($urandom % (ARCH_REGS - 1));
        r2 = (r % (ARCH_REGS - 1)) + 1;
        next_cycle();
        rename(r2, 1'b0);
        next_cycle();
        rename(r, 1'b0);
        // capture with r and r2 pending
        for (int e = 0; e < ARCH_REGS; e++) begin
            snap_in[e] = '{tag: m_tag[e], ready: m_rdy[e]};
        end
        pend = m_tag[r];
        next_cycle();
        rename(r, 1'b0);
        // r2 completes after the capture, its live entry turns ready
        wb_bus[1] = '{valid: 1'b1, tag: m_tag[r2]};
        m_rdy[r2] = 1'b1;
        next_cycle();
        restore_valid = 1'b1;
        wb_bus[0] = '{valid: 1'b1, tag: pend};
        disp_req = '{valid: 1'b1, is_branch: 1'b0, arch_dst: arch_idx_t'(r2), new_tag: 6'd63};
        #1;
        check_val("restore old tag", int'(snap_in[r2].tag), int'(old_phys));
        for (int e = 0; e < ARCH_REGS; e++) begin
            m_tag[e] = snap_in[e].tag;
            m_rdy[e] = snap_in[e].ready;
        end
        // pending snapshot tag completes during the restore
        m_rdy[r] = 1'b1;
        // same tag as the live entry, which is already ready
        m_rdy[r2] = 1'b1;
        next_cycle();
        check_lookup(r);
        check_lookup(r2);
        end_test();

        start_test("checkpoint");
        r = 1 + int'($urandom % (ARCH_REGS - 1));
        next_cycle();
        rename(r, 1'b1);
        check_val("checkpoint strobe", 1, int'(ckpt_valid));
        check_val("snapshot tag", int'(m_tag[r]), int'(snap_out[r].tag));
        next_cycle();
        branch_stall = 1'b1;
        rename(r, 1'b1);
        check_val("stalled strobe", 0, int'(ckpt_valid));
        next_cycle();
        check_lookup(r);
        end_test();

        next_cycle();
        asrt = dut.u_asserts.fail_count;
        $display("%0d tests, %0d failed, %0d assertion failures", N_TESTS, tests_failed, asrt);
        if (tests_failed == 0 && asrt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog, 200 cycles per test
    initial begin
        #(N_TESTS * 200 * 10);
        $display("Watchdog: run did not end within %0d cycles", N_TESTS * 200);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* rename_map.f */
rename_cfg_pkg.sv
rename_types_pkg.sv
wb_tag_match.sv
map_table_regs.sv
src_lookup.sv
map_next_state.sv
rename_map_top.sv
rename_map_asserts.sv
rename_map_tb.sv

/* Makefile */
# Verilator build and run of the rename map testbench
TOP = rename_map_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f rename_map.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
